//--- Makefile
VERILATOR ?= verilator
TOP       ?= bubbleDriveTb
FILELIST  ?= bubbleDriveTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -qx "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bubbleDriveTop.f
logic/bubblePkg.sv
logic/timingGenerator.sv
logic/spiLoader.sv
logic/bubbleInterface.sv
logic/ledDriver.sv
logic/bubbleDriveTop.sv
verification/flashModel.sv
verification/bubbleDriveTb.sv

//--- logic/bubbleDriveTop.sv
`timescale 1ns/1ps

module bubbleDriveTop #(
    parameter int CLK_DIV    = 12,
    parameter int PAGE_POS_W = 4
) (
    input  logic       MCLK,
    input  logic       rstN,
    input  logic       nBsEn,
    input  logic       nRepEn,
    input  logic       nBootEn,
    output logic       clkOut,
    output logic       dout0,
    output logic       dout1,
    output logic       nRomCs,
    output logic       romMosi,
    input  logic       romMiso,
    output logic       romClk,
    output logic       nWp,
    output logic       nHold,
    output logic       nAccLed,
    output logic       nWaitLed,
    output logic       nReadLed,
    output logic [7:0] nFnd,
    output logic [1:0] nAnode
);
    import bubblePkg::*;

    pageTimingT            timing;
    bufWriteT              bufWrite;
    logic                  bufValid;
    logic                  bufReady;
    logic [PAGE_POS_W-1:0] currPage;

    // flash is only ever read
    assign nWp   = 1'b1;
    assign nHold = 1'b1;

    timingGenerator #(
        .CLK_DIV    (CLK_DIV),
        .PAGE_POS_W (PAGE_POS_W)
    ) i_timing (
        .MCLK    (MCLK),
        .rstN    (rstN),
        .nBsEn   (nBsEn),
        .nRepEn  (nRepEn),
        .nBootEn (nBootEn),
        .clkOut  (clkOut),
        .timing  (timing)
    );

    spiLoader #(
        .PAGE_POS_W (PAGE_POS_W)
    ) i_loader (
        .MCLK     (MCLK),
        .rstN     (rstN),
        .timing   (timing),
        .bufWrite (bufWrite),
        .bufValid (bufValid),
        .bufReady (bufReady),
        .currPage (currPage),
        .nRomCs   (nRomCs),
        .romMosi  (romMosi),
        .romMiso  (romMiso),
        .romClk   (romClk)
    );

    bubbleInterface i_iface (
        .MCLK     (MCLK),
        .rstN     (rstN),
        .timing   (timing),
        .bufWrite (bufWrite),
        .bufValid (bufValid),
        .bufReady (bufReady),
        .dout0    (dout0),
        .dout1    (dout1)
    );

    ledDriver #(
        .PAGE_POS_W (PAGE_POS_W)
    ) i_leds (
        .MCLK     (MCLK),
        .rstN     (rstN),
        .nBootEn  (nBootEn),
        .timing   (timing),
        .currPage (currPage),
        .nAccLed  (nAccLed),
        .nWaitLed (nWaitLed),
        .nReadLed (nReadLed),
        .nFnd     (nFnd),
        .nAnode   (nAnode)
    );

endmodule

//--- logic/bubbleInterface.sv
`timescale 1ns/1ps

module bubbleInterface (
    input  logic                  MCLK,
    input  logic                  rstN,
    input  bubblePkg::pageTimingT timing,
    input  bubblePkg::bufWriteT   bufWrite,
    input  logic                  bufValid,
    output logic                  bufReady,
    output logic                  dout0,
    output logic                  dout1
);
    import bubblePkg::*;

    logic [PAGE_BITS-1:0] pageBuf;
    logic                 readType;
    logic [5:0]           evenIdx;
    logic [5:0]           oddIdx;

    // no loading while the page is being shifted out
    assign bufReady = !timing.outEn;

    always_ff @(posedge MCLK) begin
        if (bufValid && bufReady) begin
            pageBuf[bufWrite.addr] <= bufWrite.data;
        end
    end

    assign readType = timing.accType inside {accPageRead, accBootRead};
    assign evenIdx  = {timing.outIdx, 1'b0};
    assign oddIdx   = {timing.outIdx, 1'b1};

    // pair i is bits 2i and 2i+1
    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            dout0 <= 1'b0;
            dout1 <= 1'b0;
        end else if (timing.outStep && readType) begin
            dout0 <= pageBuf[evenIdx];
            dout1 <= pageBuf[oddIdx];
        end else if (!timing.outEn || !readType) begin
            dout0 <= 1'b0;
            dout1 <= 1'b0;
        end
    end

    // loader must finish inside the load window
    assert property (@(posedge MCLK) disable iff (!rstN)
        timing.outEn |-> !bufValid);

endmodule

//--- logic/bubblePkg.sv
package bubblePkg;

    // host access decoded from the control pins
    typedef enum logic [1:0] {
        accIdle,
        accShift,
        accPageRead,
        accBootRead
    } accTypeT;

    // flash opcodes
    typedef enum logic [7:0] {
        cmdRead = 8'h03
    } flashCmdT;

    // widest page position the timing bus can carry
    localparam int POS_FIELD_W = 12;

    localparam int PAGE_BYTES = 8;
    localparam int PAGE_BITS  = PAGE_BYTES * 8;
    localparam int PAIRS      = 32;

    // clkOut ticks per page, load part then output part
    localparam int LOAD_TICKS = 20;
    localparam int OUT_TICKS  = 32;
    localparam int PAGE_TICKS = LOAD_TICKS + OUT_TICKS;

    // boot loop pages live here in the flash
    localparam logic [23:0] BOOT_BASE = 24'h000800;

    typedef struct packed {
        accTypeT                accType;
        logic [POS_FIELD_W-1:0] absPos;
        logic                   pageStart;
        logic                   outEn;
        logic [4:0]             outIdx;
        logic                   outStep;
    } pageTimingT;

    typedef struct packed {
        logic [5:0] addr;
        logic       data;
    } bufWriteT;

endpackage

//--- logic/ledDriver.sv
`timescale 1ns/1ps

module ledDriver #(
    parameter int PAGE_POS_W = 4
) (
    input  logic                  MCLK,
    input  logic                  rstN,
    input  logic                  nBootEn,
    input  bubblePkg::pageTimingT timing,
    input  logic [PAGE_POS_W-1:0] currPage,
    output logic                  nAccLed,
    output logic                  nWaitLed,
    output logic                  nReadLed,
    output logic [7:0]            nFnd,
    output logic [1:0]            nAnode
);
    import bubblePkg::*;

    logic [9:0] scanCnt;
    logic [7:0] pageWide;
    logic [3:0] digit;

    // segments a..g, active high, a in the top bit
    function automatic logic [6:0] hexSeg(input logic [3:0] val);
        logic [6:0] seg;
        case (val)
            4'h0:    seg = 7'h7E;
            4'h1:    seg = 7'h30;
            4'h2:    seg = 7'h6D;
            4'h3:    seg = 7'h79;
            4'h4:    seg = 7'h33;
            4'h5:    seg = 7'h5B;
            4'h6:    seg = 7'h5F;
            4'h7:    seg = 7'h70;
            4'h8:    seg = 7'h7F;
            4'h9:    seg = 7'h7B;
            4'hA:    seg = 7'h77;
            4'hB:    seg = 7'h1F;
            4'hC:    seg = 7'h4E;
            4'hD:    seg = 7'h3D;
            4'hE:    seg = 7'h4F;
            default: seg = 7'h47;
        endcase
        return seg;
    endfunction

    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            nAccLed  <= 1'b1;
            nWaitLed <= 1'b1;
            nReadLed <= 1'b1;
            scanCnt  <= '0;
            nAnode   <= 2'b11;
        end else begin
            nWaitLed <= nBootEn;
            nReadLed <= !(timing.accType inside {accPageRead, accBootRead});
            // access LED only changes on page boundaries
            if (timing.pageStart) begin
                nAccLed <= (timing.accType == accIdle);
            end
            scanCnt <= scanCnt + 1'b1;
            if (&scanCnt) begin
                nAnode <= (nAnode == 2'b10) ? 2'b01 : 2'b10;
            end
        end
    end

    assign pageWide = 8'(currPage);
    assign digit    = nAnode[0] ? pageWide[7:4] : pageWide[3:0];
    // dp stays dark
    assign nFnd     = {~hexSeg(digit), 1'b1};

endmodule

//--- logic/spiLoader.sv
`timescale 1ns/1ps

module spiLoader #(
    parameter int PAGE_POS_W = 4
) (
    input  logic                  MCLK,
    input  logic                  rstN,
    input  bubblePkg::pageTimingT timing,
    output bubblePkg::bufWriteT   bufWrite,
    output logic                  bufValid,
    input  logic                  bufReady,
    output logic [PAGE_POS_W-1:0] currPage,
    output logic                  nRomCs,
    output logic                  romMosi,
    input  logic                  romMiso,
    output logic                  romClk
);
    import bubblePkg::*;

    typedef enum logic [2:0] {ldIdle, ldCmd, ldAddr, ldData, ldDone} ldStateT;

    ldStateT               state;
    logic [5:0]            bitCnt;
    logic [31:0]           txShift;
    logic [PAGE_POS_W-1:0] pagePos;
    logic [PAGE_POS_W-1:0] fetchPos;
    logic [23:0]           pageAddr;
    logic                  startFetch;
    logic                  busy;
    logic                  stall;
    logic                  sclkRise;
    logic                  sclkFall;
    logic                  lastBit;

    assign pagePos  = timing.absPos[PAGE_POS_W-1:0];
    assign pageAddr = 24'(pagePos * PAGE_BYTES) +
                      ((timing.accType == accBootRead) ? BOOT_BASE : 24'h000000);

    assign startFetch = (state == ldIdle) && timing.pageStart &&
                        (timing.accType inside {accPageRead, accBootRead});
    assign busy = state inside {ldCmd, ldAddr, ldData};

    // buffer back-pressure freezes the SPI clock high
    assign stall    = bufValid && !bufReady;
    assign sclkRise = busy && !romClk;
    assign sclkFall = busy && romClk && !stall;
    assign romMosi  = txShift[31];

    always_comb begin
        case (state)
            ldCmd:   lastBit = (bitCnt == 6'd7);
            ldAddr:  lastBit = (bitCnt == 6'd23);
            default: lastBit = (bitCnt == 6'(PAGE_BITS - 1));
        endcase
    end

    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            state    <= ldIdle;
            bitCnt   <= '0;
            txShift  <= '0;
            fetchPos <= '0;
            currPage <= '0;
            nRomCs   <= 1'b1;
            romClk   <= 1'b0;
            bufValid <= 1'b0;
        end else begin
            if (bufValid && bufReady) begin
                bufValid <= 1'b0;
            end
            // mode 0, sample MISO as the clock goes high
            if (sclkRise) begin
                romClk <= 1'b1;
                if (state == ldData) begin
                    bufValid <= 1'b1;
                end
            end
            if (sclkFall) begin
                romClk  <= 1'b0;
                txShift <= {txShift[30:0], 1'b0};
                bitCnt  <= lastBit ? '0 : bitCnt + 1'b1;
            end
            case (state)
                ldIdle: begin
                    if (startFetch) begin
                        state    <= ldCmd;
                        nRomCs   <= 1'b0;
                        txShift  <= {cmdRead, pageAddr};
                        fetchPos <= pagePos;
                        bitCnt   <= '0;
                    end
                end
                ldCmd: begin
                    if (sclkFall && lastBit) begin
                        state <= ldAddr;
                    end
                end
                ldAddr: begin
                    if (sclkFall && lastBit) begin
                        state <= ldData;
                    end
                end
                ldData: begin
                    if (sclkFall && lastBit) begin
                        state <= ldDone;
                    end
                end
                default: begin
                    nRomCs   <= 1'b1;
                    currPage <= fetchPos;
                    state    <= ldIdle;
                end
            endcase
        end
    end

    // one buffer write per received bit, index follows stream order
    always_ff @(posedge MCLK) begin
        if (sclkRise && (state == ldData)) begin
            bufWrite.addr <= bitCnt;
            bufWrite.data <= romMiso;
        end
    end

    // chip select held for the whole transfer
    assert property (@(posedge MCLK) disable iff (!rstN)
        $fell(nRomCs) |-> !nRomCs until_with (state == ldDone));

endmodule

//--- logic/timingGenerator.sv
`timescale 1ns/1ps

module timingGenerator #(
    parameter int CLK_DIV    = 12,
    parameter int PAGE_POS_W = 4
) (
    input  logic                  MCLK,
    input  logic                  rstN,
    input  logic                  nBsEn,
    input  logic                  nRepEn,
    input  logic                  nBootEn,
    output logic                  clkOut,
    output bubblePkg::pageTimingT timing
);
    import bubblePkg::*;

    localparam int DIV_W = $clog2(CLK_DIV);

    logic [DIV_W-1:0]      divCnt;
    logic                  riseStb;
    logic [5:0]            tickCnt;
    logic [PAGE_POS_W-1:0] absPos;
    accTypeT               accType;
    logic                  pageStart;
    logic                  outStep;
    logic                  outEn;

    // pin priority: enable, then boot, then replicate
    function automatic accTypeT decodeAcc(input logic bs, input logic rep, input logic boot);
        if (bs) begin
            return accIdle;
        end else if (!boot) begin
            return accBootRead;
        end else if (!rep) begin
            return accPageRead;
        end
        return accShift;
    endfunction

    // high the MCLK before clkOut rises
    assign riseStb = (divCnt == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            divCnt <= '0;
            clkOut <= 1'b0;
        end else if (riseStb) begin
            divCnt <= '0;
            clkOut <= 1'b1;
        end else begin
            divCnt <= divCnt + 1'b1;
            if (divCnt == DIV_W'(CLK_DIV / 2 - 1)) begin
                clkOut <= 1'b0;
            end
        end
    end

    // page ticks advance on clkOut rises
    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            tickCnt   <= '0;
            absPos    <= '0;
            accType   <= accIdle;
            pageStart <= 1'b0;
            outStep   <= 1'b0;
        end else begin
            pageStart <= 1'b0;
            outStep   <= 1'b0;
            if (riseStb) begin
                if (accType == accIdle) begin
                    // restart page 0, position kept
                    if (!nBsEn) begin
                        tickCnt   <= '0;
                        accType   <= decodeAcc(nBsEn, nRepEn, nBootEn);
                        pageStart <= 1'b1;
                    end
                end else if (tickCnt == 6'(PAGE_TICKS - 1)) begin
                    tickCnt   <= '0;
                    absPos    <= absPos + 1'b1;
                    accType   <= decodeAcc(nBsEn, nRepEn, nBootEn);
                    pageStart <= 1'b1;
                end else begin
                    tickCnt <= tickCnt + 1'b1;
                    outStep <= (tickCnt >= 6'(LOAD_TICKS - 1));
                end
            end
        end
    end

    assign outEn = (accType != accIdle) && (tickCnt >= 6'(LOAD_TICKS));

    always_comb begin
        timing.accType   = accType;
        timing.absPos    = POS_FIELD_W'(absPos);
        timing.pageStart = pageStart;
        timing.outEn     = outEn;
        timing.outIdx    = 5'(tickCnt - 6'(LOAD_TICKS));
        timing.outStep   = outStep;
    end

    // every output step falls inside the 32 pair window
    assert property (@(posedge MCLK) disable iff (!rstN)
        timing.outStep |-> timing.outEn && (int'(tickCnt) - LOAD_TICKS < PAIRS));

endmodule

//--- verification/bubbleDriveTb.sv
`timescale 1ns/1ps

module bubbleDriveTb;
    import bubblePkg::*;

    localparam int CLK_DIV    = 12;
    localparam int PAGE_POS_W = 4;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 6;

    typedef struct packed {
        logic       nRep;
        logic       nBoot;
        logic [7:0] pages;
        logic [7:0] startPos;
    } testEntryT;

    // one row per access with nRepEn, nBootEn, pages and starting absPos
    // absPos carries over from one access to the next
    localparam testEntryT TESTS [NUM_TESTS] = '{
        '{1'b0, 1'b1, 8'd3, 8'd0},
        '{1'b1, 1'b0, 8'd2, 8'd3},
        '{1'b1, 1'b1, 8'd3, 8'd5},
        '{1'b0, 1'b1, 8'd2, 8'd8},
        '{1'b1, 1'b1, 8'd5, 8'd10},
        '{1'b0, 1'b1, 8'd3, 8'd15}
    };

    // active-high segments a..g per hex digit
    localparam logic [6:0] SEG [16] = '{
        7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
        7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47
    };

    logic        MCLK;
    logic        rstN;
    logic        nBsEn;
    logic        nRepEn;
    logic        nBootEn;
    logic        clkOut;
    logic        dout0;
    logic        dout1;
    logic        nRomCs;
    logic        romMosi;
    logic        romMiso;
    logic        romClk;
    logic        nWp;
    logic        nHold;
    logic        nAccLed;
    logic        nWaitLed;
    logic        nReadLed;
    logic [7:0]  nFnd;
    logic [1:0]  nAnode;
    logic [7:0]  flashCmd;
    logic [23:0] flashAddr;
    int          errCount;
    int          testsPassed;
    int          testsFailed;
    int          fndChecks;
    time         lastClkEdge = 0;

    bubbleDriveTop #(
        .CLK_DIV    (CLK_DIV),
        .PAGE_POS_W (PAGE_POS_W)
    ) i_dut (
        .MCLK     (MCLK),
        .rstN     (rstN),
        .nBsEn    (nBsEn),
        .nRepEn   (nRepEn),
        .nBootEn  (nBootEn),
        .clkOut   (clkOut),
        .dout0    (dout0),
        .dout1    (dout1),
        .nRomCs   (nRomCs),
        .romMosi  (romMosi),
        .romMiso  (romMiso),
        .romClk   (romClk),
        .nWp      (nWp),
        .nHold    (nHold),
        .nAccLed  (nAccLed),
        .nWaitLed (nWaitLed),
        .nReadLed (nReadLed),
        .nFnd     (nFnd),
        .nAnode   (nAnode)
    );

    flashModel i_flash (
        .nCs      (nRomCs),
        .sclk     (romClk),
        .mosi     (romMosi),
        .miso     (romMiso),
        .lastCmd  (flashCmd),
        .lastAddr (flashAddr)
    );

    initial begin
        MCLK = 1'b0;
        forever #(CLK_PERIOD / 2) MCLK = ~MCLK;
    end

    // bit n of a page is byte n/8 taken MSB first
    function automatic logic expectedBit(input logic [23:0] base, input int bitNum);
        logic [23:0] byteAddr;
        logic [7:0]  value;
        byteAddr = base + 24'(bitNum / 8);
        value    = byteAddr[7:0] ^ 8'h5A;
        return value[3'(7 - bitNum % 8)];
    endfunction

    task automatic logError(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        errCount++;
    endtask

    task automatic finishTest(input string name, input int errBefore);
        if (errCount == errBefore) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errCount - errBefore);
        end
    endtask

    // clkOut runs at MCLK / CLK_DIV with equal high and low halves
    always @(clkOut) begin
        if (rstN === 1'b1 && lastClkEdge != 0 &&
            $time - lastClkEdge != CLK_DIV / 2 * CLK_PERIOD) begin
            logError($sformatf("clkOut edge %0t ns after the previous one, expected %0d ns",
                $time - lastClkEdge, CLK_DIV / 2 * CLK_PERIOD));
        end
        lastClkEdge = $time;
    end

    task automatic checkAfterReset();
        int errBefore;
        errBefore = errCount;
        if (dout0 !== 1'b0 || dout1 !== 1'b0) begin
            logError("dout0/dout1 not low after reset");
        end
        if (romClk !== 1'b0 || nRomCs !== 1'b1) begin
            logError("flash clock or chip select not idle after reset");
        end
        if ({nAccLed, nWaitLed, nReadLed} !== 3'b111 || nAnode !== 2'b11) begin
            logError("LED or display anode on after reset");
        end
        if (nWp !== 1'b1 || nHold !== 1'b1) begin
            logError("nWp/nHold not tied high");
        end
        finishTest("reset", errBefore);
    endtask

    task automatic runTest(input int k);
        testEntryT   entry;
        int          errBefore;
        int          pos;
        int          pair;
        int          waitCycles;
        logic        isRead;
        logic [23:0] base;
        logic        exp0;
        logic        exp1;
        entry     = TESTS[k];
        errBefore = errCount;
        isRead    = !entry.nBoot || !entry.nRep;
        @(negedge MCLK);
        nRepEn  = entry.nRep;
        nBootEn = entry.nBoot;
        nBsEn   = 1'b0;
        wait (nAccLed == 1'b0);
        for (int p = 0; p < int'(entry.pages); p++) begin
            pos  = (int'(entry.startPos) + p) % (1 << PAGE_POS_W);
            base = (entry.nBoot ? 24'h000000 : BOOT_BASE) + 24'(pos * PAGE_BYTES);
            for (int t = 0; t < PAGE_TICKS; t++) begin
                @(negedge clkOut);
                @(negedge MCLK);
                pair = t - LOAD_TICKS;
                exp0 = 1'b0;
                exp1 = 1'b0;
                if (isRead && pair >= 0) begin
                    exp0 = expectedBit(base, 2 * pair);
                    exp1 = expectedBit(base, 2 * pair + 1);
                end
                if (dout0 !== exp0 || dout1 !== exp1) begin
                    logError($sformatf("page %0d tick %0d: dout %b%b, expected %b%b",
                        pos, t, dout0, dout1, exp0, exp1));
                end
                if (nAccLed !== 1'b0 || nWaitLed !== entry.nBoot || nReadLed !== !isRead) begin
                    logError($sformatf("page %0d tick %0d: LEDs acc/wait/read %b%b%b",
                        pos, t, nAccLed, nWaitLed, nReadLed));
                end
                if (isRead && pair == 0 && (flashCmd !== 8'h03 || flashAddr !== base)) begin
                    logError($sformatf("page %0d: flash got cmd %h addr %h, expected 03 %h",
                        pos, flashCmd, flashAddr, base));
                end
                // digit 0 shows the low nibble of the page just loaded
                if (isRead && pair >= 0 && nAnode[0] === 1'b0) begin
                    fndChecks++;
                    if (nFnd !== {~SEG[4'(pos)], 1'b1}) begin
                        logError($sformatf("page %0d: nFnd %h on digit 0", pos, nFnd));
                    end
                end
                // digit 1 shows the page bits above the low nibble
                if (isRead && pair >= 0 && nAnode[1] === 1'b0) begin
                    if (nFnd !== {~SEG[4'(pos >> 4)], 1'b1}) begin
                        logError($sformatf("page %0d: nFnd %h on digit 1", pos, nFnd));
                    end
                end
                // release early in the last page so it ends at the next boundary
                if (p == int'(entry.pages) - 1 && t == 0) begin
                    nBsEn = 1'b1;
                end
            end
        end
        // the boundary follows the last clkOut fall within one clkOut period
        waitCycles = 0;
        while (nAccLed !== 1'b1 && waitCycles < CLK_DIV) begin
            @(negedge MCLK);
            waitCycles++;
        end
        if (nAccLed !== 1'b1) begin
            logError("nAccLed did not rise at the page boundary after nBsEn was released");
        end
        @(negedge MCLK);
        if (dout0 !== 1'b0 || dout1 !== 1'b0 || nReadLed !== 1'b1) begin
            logError("outputs not idle after the access ended");
        end
        nRepEn  = 1'b1;
        nBootEn = 1'b1;
        finishTest($sformatf("%0d, %0d pages from %0d", k, entry.pages, entry.startPos),
            errBefore);
    endtask

    initial begin : watchdog
        int pageCount;
        int limitNs;
        pageCount = 0;
        for (int k = 0; k < NUM_TESTS; k++) begin
            pageCount += int'(TESTS[k].pages);
        end
        // extra pages cover reset and the idle gaps between accesses
        limitNs = (pageCount + 2 * NUM_TESTS + 4) * PAGE_TICKS * CLK_DIV * CLK_PERIOD;
        #(limitNs);
        $display("ERROR: run timed out after %0d ns waiting on the DUT", limitNs);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rstN        = 1'b0;
        nBsEn       = 1'b1;
        nRepEn      = 1'b1;
        nBootEn     = 1'b1;
        errCount    = 0;
        testsPassed = 0;
        testsFailed = 0;
        fndChecks   = 0;
        repeat (8) @(negedge MCLK);
        rstN = 1'b1;
        @(negedge MCLK);
        checkAfterReset();
        for (int k = 0; k < NUM_TESTS; k++) begin
            runTest(k);
        end
        if (fndChecks == 0) begin
            $display("ERROR: digit 0 of the display was never active during a read");
            errCount++;
        end
        $display("summary: %0d tests passed, %0d failed, %0d errors, %0d display checks",
            testsPassed, testsFailed, errCount, fndChecks);
        if (errCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verification/flashModel.sv
`timescale 1ns/1ps

module flashModel (
    input  logic        nCs,
    input  logic        sclk,
    input  logic        mosi,
    output logic        miso,
    output logic [7:0]  lastCmd,
    output logic [23:0] lastAddr
);
    logic [31:0] rxShift = '0;
    int          rxCnt   = 0;
    logic        misoBit = 1'b0;
    logic [7:0]  cmdReg  = '0;
    logic [23:0] addrReg = '0;
    int          dataIdx;
    logic [23:0] byteAddr;
    logic [7:0]  byteVal;

    assign miso     = misoBit;
    assign lastCmd  = cmdReg;
    assign lastAddr = addrReg;

    // command and address shift in on rising edges, count restarts per transfer
    always @(posedge sclk or posedge nCs) begin
        if (nCs) begin
            rxCnt <= 0;
        end else begin
            rxShift <= {rxShift[30:0], mosi};
            if (rxCnt == 31) begin
                {cmdReg, addrReg} <= {rxShift[30:0], mosi};
            end
            rxCnt <= rxCnt + 1;
        end
    end

    // data out on falling edges, byte a reads as a xor 0x5A
    always @(negedge sclk) begin
        if (!nCs && rxCnt >= 32) begin
            dataIdx  = rxCnt - 32;
            byteAddr = addrReg + 24'(dataIdx / 8);
            byteVal  = byteAddr[7:0] ^ 8'h5A;
            misoBit <= byteVal[3'(7 - dataIdx % 8)];
        end
    end

endmodule
